//--- icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

    // Byte address and line geometry
    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = $clog2(LINE_W / 8);

    // Set count drives the index and tag split
    localparam int NSET    = 256;
    localparam int INDEX_W = $clog2(NSET);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

endpackage

`default_nettype wire

//--- icache_types_pkg.sv
`default_nettype none

package icache_types_pkg;

    import icache_cfg_pkg::*;

    typedef logic [INDEX_W-1:0] index_t;

    typedef logic [LINE_W-1:0] line_t;

    // One tag RAM word, valid on top
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        MAINT
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- ram_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if
    import icache_types_pkg::*;
#(
    parameter type DATA_T = line_t
);

    logic   en;
    logic   we;
    index_t addr;
    DATA_T  wdata;
    DATA_T  rdata;

    modport master (output en, output we, output addr, output wdata, input rdata);

    modport ram (input en, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- icache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ram
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
#(
    parameter type DATA_T = line_t
) (
    input  logic           clk,
    ram_port_if.ram        port_i
);

    DATA_T mem [NSET];

    // Read returns the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        if (port_i.en) begin
            if (port_i.we) begin
                mem[port_i.addr] <= port_i.wdata;
            end
            port_i.rdata <= mem[port_i.addr];
        end
    end

endmodule

`default_nettype wire

//--- icache_maint.sv
`timescale 1ns/1ps
`default_nettype none

module icache_maint
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
#(
    parameter int NWAY = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 invalid_i,
    input  logic                                 cacop_i,
    input  logic [((NWAY > 1) ? $clog2(NWAY) : 1)-1:0] cacop_way_i,
    input  index_t                               cacop_index_i,
    input  logic                                 ctrl_idle_i,
    output logic                                 maint_busy_o,
    output logic                                 maint_we_o,
    output logic [NWAY-1:0]                      maint_way_o,
    output index_t                               maint_index_o,
    output logic                                 cacop_ack_o
);

    logic            start_sweep;
    logic            start_op;
    logic            sweep_active;
    index_t          sweep_cnt;
    logic            op_pending;
    logic [NWAY-1:0] op_way;
    index_t          op_index;

    // Invalidate wins over cacop
    assign start_sweep = ctrl_idle_i & invalid_i;
    assign start_op    = ctrl_idle_i & cacop_i & ~invalid_i;

    //////////////////////////////
    // Sweep counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_active <= 1'b1;
            sweep_cnt    <= '0;
        end else if (start_sweep) begin
            sweep_active <= 1'b1;
            sweep_cnt    <= '0;
        end else if (sweep_active) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == index_t'(NSET - 1)) begin
                sweep_active <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Single-entry clear
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            op_pending  <= 1'b0;
            cacop_ack_o <= 1'b0;
        end else begin
            op_pending  <= start_op;
            cacop_ack_o <= op_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (start_op) begin
            op_way   <= NWAY'(1) << cacop_way_i;
            op_index <= cacop_index_i;
        end
    end

    // Busy covers the request cycle so no lookup slips in
    assign maint_busy_o  = sweep_active | op_pending | start_sweep | start_op;
    assign maint_we_o    = sweep_active | op_pending;
    assign maint_way_o   = sweep_active ? '1 : op_way;
    assign maint_index_o = sweep_active ? sweep_cnt : op_index;

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
#(
    parameter int NWAY = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rreq_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output logic              rreq_ack_o,
    output logic              rvalid_o,
    output line_t             rdata_o,
    output logic              axi_rreq_o,
    output logic [ADDR_W-1:0] axi_addr_o,
    input  logic              axi_rdy_i,
    input  logic              axi_rvalid_i,
    input  line_t             axi_data_i,
    input  logic              maint_busy_i,
    input  logic              maint_we_i,
    input  logic [NWAY-1:0]   maint_way_i,
    input  index_t            maint_index_i,
    output logic              ctrl_idle_o,
    ram_port_if.master        tag_port_o [NWAY],
    ram_port_if.master        data_port_o [NWAY]
);

    ctrl_state_t       state;
    ctrl_state_t       state_nxt;
    logic [ADDR_W-1:0] req_addr;
    logic [TAG_W-1:0]  req_tag;
    index_t            req_index;
    logic [2:0]        lfsr;
    logic [2:0]        victim;
    tag_entry_t        tag_rd [NWAY];
    line_t             data_rd [NWAY];
    logic [NWAY-1:0]   hit_way;
    line_t             hit_line;
    logic              hit;
    logic              miss;
    logic              idle;
    logic              accept;
    logic              fill;
    logic [NWAY-1:0]   tag_en;
    logic [NWAY-1:0]   tag_we;
    logic [NWAY-1:0]   data_en;
    logic [NWAY-1:0]   data_we;
    tag_entry_t        tag_wdata;
    index_t            ram_addr;

    //////////////////////////////
    // Lookup and compare
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= raddr_i;
        end
    end

    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (hit_way[w]) begin
                hit_line = data_rd[w];
            end
        end
    end

    assign hit  = (state == LOOKUP) & (|hit_way);
    assign miss = (state == LOOKUP) & ~(|hit_way);

    // A hitting lookup frees the controller in the same cycle
    assign idle        = (state == IDLE) | hit;
    assign ctrl_idle_o = idle;
    assign rreq_ack_o  = idle & ~maint_busy_i;
    assign accept      = rreq_ack_o & rreq_i;

    // Refill request and line pass-through
    assign axi_rreq_o = miss | (state == REFILL_REQ);
    assign axi_addr_o = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign fill       = axi_rvalid_i & ((state == REFILL_WAIT) | (axi_rreq_o & axi_rdy_i));
    assign rvalid_o   = hit | fill;
    assign rdata_o    = fill ? axi_data_i : hit_line;

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MAINT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, LOOKUP: begin
                if (miss) begin
                    if (fill) state_nxt = IDLE;
                    else if (axi_rdy_i) state_nxt = REFILL_WAIT;
                    else state_nxt = REFILL_REQ;
                end else if (maint_busy_i) begin
                    state_nxt = MAINT;
                end else if (rreq_i) begin
                    state_nxt = LOOKUP;
                end else begin
                    state_nxt = IDLE;
                end
            end
            REFILL_REQ: begin
                if (fill) state_nxt = IDLE;
                else if (axi_rdy_i) state_nxt = REFILL_WAIT;
            end
            REFILL_WAIT: begin
                if (fill) state_nxt = IDLE;
            end
            MAINT: begin
                if (!maint_busy_i) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Victim pick, x^3 + x^2 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 3'b001;
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign victim = lfsr & 3'(NWAY - 1);

    //////////////////////////////
    // RAM port drive
    //////////////////////////////

    always_comb begin
        tag_en    = '0;
        tag_we    = '0;
        data_en   = '0;
        data_we   = '0;
        tag_wdata = '0;
        ram_addr  = raddr_i[OFFSET_W +: INDEX_W];
        if (maint_we_i) begin
            tag_en   = maint_way_i;
            tag_we   = maint_way_i;
            ram_addr = maint_index_i;
        end else if (fill) begin
            for (int w = 0; w < NWAY; w++) begin
                if (victim == 3'(w)) begin
                    tag_en[w]  = 1'b1;
                    tag_we[w]  = 1'b1;
                    data_en[w] = 1'b1;
                    data_we[w] = 1'b1;
                end
            end
            tag_wdata.valid = 1'b1;
            tag_wdata.tag   = req_tag;
            ram_addr        = req_index;
        end else if (accept) begin
            tag_en  = '1;
            data_en = '1;
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        assign tag_port_o[w].en     = tag_en[w];
        assign tag_port_o[w].we     = tag_we[w];
        assign tag_port_o[w].addr   = ram_addr;
        assign tag_port_o[w].wdata  = tag_wdata;
        assign data_port_o[w].en    = data_en[w];
        assign data_port_o[w].we    = data_we[w];
        assign data_port_o[w].addr  = ram_addr;
        assign data_port_o[w].wdata = axi_data_i;
        assign tag_rd[w]            = tag_port_o[w].rdata;
        assign data_rd[w]           = data_port_o[w].rdata;
        assign hit_way[w]           = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
#(
    parameter int NWAY = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // Fetch side
    input  logic                                 rreq_i,
    input  logic [ADDR_W-1:0]                    raddr_i,
    output logic                                 rreq_ack_o,
    output logic                                 rvalid_o,
    output line_t                                rdata_o,

    // Memory side
    output logic                                 axi_rreq_o,
    output logic [ADDR_W-1:0]                    axi_addr_o,
    input  logic                                 axi_rdy_i,
    input  logic                                 axi_rvalid_i,
    input  line_t                                axi_data_i,

    // Maintenance
    input  logic                                 invalid_i,
    input  logic                                 cacop_i,
    input  logic [((NWAY > 1) ? $clog2(NWAY) : 1)-1:0] cacop_way_i,
    input  index_t                               cacop_index_i,
    output logic                                 cacop_ack_o
);

    logic            maint_busy;
    logic            maint_we;
    logic [NWAY-1:0] maint_way;
    index_t          maint_index;
    logic            ctrl_idle;

    ram_port_if #(.DATA_T(tag_entry_t)) tag_port [NWAY] ();
    ram_port_if #(.DATA_T(line_t))      data_port [NWAY] ();

    icache_maint #(
        .NWAY (NWAY)
    ) u_maint (
        .clk           (clk),
        .rst           (rst),
        .invalid_i     (invalid_i),
        .cacop_i       (cacop_i),
        .cacop_way_i   (cacop_way_i),
        .cacop_index_i (cacop_index_i),
        .ctrl_idle_i   (ctrl_idle),
        .maint_busy_o  (maint_busy),
        .maint_we_o    (maint_we),
        .maint_way_o   (maint_way),
        .maint_index_o (maint_index),
        .cacop_ack_o   (cacop_ack_o)
    );

    icache_ctrl #(
        .NWAY (NWAY)
    ) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .rreq_i        (rreq_i),
        .raddr_i       (raddr_i),
        .rreq_ack_o    (rreq_ack_o),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .axi_rreq_o    (axi_rreq_o),
        .axi_addr_o    (axi_addr_o),
        .axi_rdy_i     (axi_rdy_i),
        .axi_rvalid_i  (axi_rvalid_i),
        .axi_data_i    (axi_data_i),
        .maint_busy_i  (maint_busy),
        .maint_we_i    (maint_we),
        .maint_way_i   (maint_way),
        .maint_index_i (maint_index),
        .ctrl_idle_o   (ctrl_idle),
        .tag_port_o    (tag_port),
        .data_port_o   (data_port)
    );

    // One tag and one data array per way
    for (genvar w = 0; w < NWAY; w++) begin : g_ram
        icache_ram #(
            .DATA_T (tag_entry_t)
        ) u_tag_ram (
            .clk    (clk),
            .port_i (tag_port[w])
        );

        icache_ram #(
            .DATA_T (line_t)
        ) u_data_ram (
            .clk    (clk),
            .port_i (data_port[w])
        );
    end

endmodule

`default_nettype wire

//--- tb_icache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_assertions (
    input  logic clk,
    input  logic rst,
    input  logic rreq_i,
    input  logic rreq_ack_i,
    input  logic rvalid_i,
    input  logic axi_rreq_i,
    input  logic axi_rdy_i,
    input  logic sweep_active_i
);

    int   error_count = 0;
    logic in_flight;
    logic refill_open;

    // Set on accept, cleared by the returning line
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (rreq_i && rreq_ack_i) begin
            in_flight <= 1'b1;
        end else if (rvalid_i) begin
            in_flight <= 1'b0;
        end
    end

    // Open from the refill request until the line comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_open <= 1'b0;
        end else if (rvalid_i) begin
            refill_open <= 1'b0;
        end else if (axi_rreq_i) begin
            refill_open <= 1'b1;
        end
    end

    rvalid_needs_accept: assert property (@(posedge clk) disable iff (rst)
        rvalid_i |-> in_flight)
    else begin
        error_count++;
        $error("rvalid_o rose without an accepted request");
    end

    // Refill request is a level held until the memory side takes it
    refill_req_held: assert property (@(posedge clk) disable iff (rst)
        (axi_rreq_i && !axi_rdy_i) |=> axi_rreq_i)
    else begin
        error_count++;
        $error("axi_rreq_o dropped before axi_rdy_i");
    end

    no_ack_when_busy: assert property (@(posedge clk) disable iff (rst)
        (sweep_active_i || axi_rreq_i || refill_open) |-> !rreq_ack_i)
    else begin
        error_count++;
        $error("rreq_ack_o high during a sweep or a refill");
    end

endmodule

bind icache_top tb_icache_assertions u_assert (
    .clk            (clk),
    .rst            (rst),
    .rreq_i         (rreq_i),
    .rreq_ack_i     (rreq_ack_o),
    .rvalid_i       (rvalid_o),
    .axi_rreq_i     (axi_rreq_o),
    .axi_rdy_i      (axi_rdy_i),
    .sweep_active_i (u_maint.sweep_active)
);

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
;

    localparam int NWAY    = 2;
    localparam int WAY_W   = (NWAY > 1) ? $clog2(NWAY) : 1;
    localparam int NSTEP   = 23;
    localparam int DELAY_N = 32;

    typedef enum logic [1:0] {OP_READ, OP_CACOP, OP_INVAL} op_t;
    typedef enum logic [1:0] {EXP_HIT, EXP_MISS, EXP_ANY} expect_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [WAY_W-1:0]  way;
        index_t            index;
        expect_t           exp;
    } step_t;

    // Index 0x04 gets three tags, so the victim choice decides some hits
    localparam step_t STEPS [NSTEP] = '{
        '{OP_READ,  32'h0000_1040, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_1048, 1'b0, 8'h00, EXP_HIT},
        '{OP_READ,  32'h0000_104C, 1'b0, 8'h00, EXP_HIT},
        '{OP_READ,  32'h0000_2040, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_3040, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_1040, 1'b0, 8'h00, EXP_ANY},
        '{OP_READ,  32'h0000_2044, 1'b0, 8'h00, EXP_ANY},
        '{OP_READ,  32'h0000_3040, 1'b0, 8'h00, EXP_ANY},
        '{OP_READ,  32'h0000_3048, 1'b0, 8'h00, EXP_HIT},
        '{OP_READ,  32'h0000_50A0, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_50A4, 1'b0, 8'h00, EXP_HIT},
        '{OP_CACOP, 32'h0000_0000, 1'b0, 8'h0A, EXP_ANY},
        '{OP_CACOP, 32'h0000_0000, 1'b1, 8'h0A, EXP_ANY},
        '{OP_READ,  32'h0000_50A0, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_50AC, 1'b0, 8'h00, EXP_HIT},
        '{OP_READ,  32'h0000_7FF0, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_7FF4, 1'b0, 8'h00, EXP_HIT},
        '{OP_INVAL, 32'h0000_0000, 1'b0, 8'h00, EXP_ANY},
        '{OP_READ,  32'h0000_50A0, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_7FF0, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'h0000_7FF8, 1'b0, 8'h00, EXP_HIT},
        '{OP_READ,  32'hFFFF_F00C, 1'b0, 8'h00, EXP_MISS},
        '{OP_READ,  32'hFFFF_F000, 1'b0, 8'h00, EXP_HIT}
    };

    logic              clk = 1'b0;
    logic              rst;
    logic              rreq_i;
    logic [ADDR_W-1:0] raddr_i;
    logic              rreq_ack_o;
    logic              rvalid_o;
    line_t             rdata_o;
    logic              axi_rreq_o;
    logic [ADDR_W-1:0] axi_addr_o;
    logic              axi_rdy_i;
    logic              axi_rvalid_i;
    line_t             axi_data_i;
    logic              invalid_i;
    logic              cacop_i;
    logic [WAY_W-1:0]  cacop_way_i;
    index_t            cacop_index_i;
    logic              cacop_ack_o;
    int unsigned       rdy_delay [DELAY_N];
    int unsigned       data_delay [DELAY_N];

    always #4 clk = ~clk;

    icache_top #(
        .NWAY (NWAY)
    ) uut (
        .clk           (clk),
        .rst           (rst),
        .rreq_i        (rreq_i),
        .raddr_i       (raddr_i),
        .rreq_ack_o    (rreq_ack_o),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .axi_rreq_o    (axi_rreq_o),
        .axi_addr_o    (axi_addr_o),
        .axi_rdy_i     (axi_rdy_i),
        .axi_rvalid_i  (axi_rvalid_i),
        .axi_data_i    (axi_data_i),
        .invalid_i     (invalid_i),
        .cacop_i       (cacop_i),
        .cacop_way_i   (cacop_way_i),
        .cacop_index_i (cacop_index_i),
        .cacop_ack_o   (cacop_ack_o)
    );

    //////////////////////////////
    // Reference model and checks
    //////////////////////////////

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
        return addr & ~ADDR_W'(LINE_W / 8 - 1);
    endfunction

    function automatic line_t model_line(input logic [ADDR_W-1:0] addr);
        return {4{line_base(addr) ^ 32'h5A3C_96E1}};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    //////////////////////////////
    // Request side operations
    //////////////////////////////

    task automatic issue_read(input logic [ADDR_W-1:0] addr, input expect_t exp);
        bit got_hit;
        @(negedge clk);
        rreq_i  = 1'b1;
        raddr_i = addr;
        @(posedge clk);
        while (!rreq_ack_o) @(posedge clk);
        @(negedge clk);
        rreq_i = 1'b0;
        // One cycle after acceptance
        @(posedge clk);
        got_hit = !axi_rreq_o;
        if (exp != EXP_ANY) begin
            check_value("lookup hit", got_hit, exp == EXP_HIT);
        end
        if (got_hit) begin
            check_value("rvalid_o", rvalid_o, 1'b1);
        end else begin
            check_value("axi_addr_o", axi_addr_o, line_base(addr));
            while (!rvalid_o) @(posedge clk);
            check_value("axi_rvalid_i with rvalid_o", axi_rvalid_i, 1'b1);
        end
        check_value("rdata_o", rdata_o, model_line(addr));
    endtask

    task automatic wait_for_sweep();
        int unsigned low_cycles;
        low_cycles = 0;
        @(posedge clk);
        while (!rreq_ack_o) begin
            check_value("rvalid_o", rvalid_o, 1'b0);
            check_value("axi_rreq_o", axi_rreq_o, 1'b0);
            check_value("cacop_ack_o", cacop_ack_o, 1'b0);
            low_cycles++;
            @(posedge clk);
        end
        check_value("sweep at least NSET cycles", low_cycles >= NSET, 1'b1);
    endtask

    task automatic clear_entry(input logic [WAY_W-1:0] way, input index_t index);
        @(negedge clk);
        cacop_i       = 1'b1;
        cacop_way_i   = way;
        cacop_index_i = index;
        @(posedge clk);
        @(negedge clk);
        cacop_i = 1'b0;
        @(posedge clk);
        check_value("cacop_ack_o", cacop_ack_o, 1'b0);
        @(posedge clk);
        check_value("cacop_ack_o", cacop_ack_o, 1'b1);
    endtask

    task automatic invalidate_all();
        @(negedge clk);
        invalid_i = 1'b1;
        @(posedge clk);
        @(negedge clk);
        invalid_i = 1'b0;
        wait_for_sweep();
    endtask

    // Memory side, one single-beat refill at a time
    initial begin : memory_model
        int unsigned n;
        logic [ADDR_W-1:0] req_line;
        n = 0;
        forever begin
            @(negedge clk);
            if (axi_rreq_o) begin
                req_line = axi_addr_o;
                repeat (rdy_delay[n]) @(negedge clk);
                axi_rdy_i = 1'b1;
                if (data_delay[n] == 0) begin
                    axi_rvalid_i = 1'b1;
                    axi_data_i   = model_line(req_line);
                end
                @(negedge clk);
                axi_rdy_i    = 1'b0;
                axi_rvalid_i = 1'b0;
                if (data_delay[n] != 0) begin
                    repeat (data_delay[n] - 1) @(negedge clk);
                    axi_rvalid_i = 1'b1;
                    axi_data_i   = model_line(req_line);
                    @(negedge clk);
                    axi_rvalid_i = 1'b0;
                end
                n = (n + 1) % DELAY_N;
            end
        end
    end

    always @(negedge clk) begin
        if (uut.u_assert.error_count != 0) begin
            fail_run("A protocol assertion failed");
        end
    end

    initial begin : watchdog
        repeat (NSTEP * 40 + 2 * NSET) @(posedge clk);
        fail_run("Timeout: the cache stopped responding before the tests finished");
    end

    initial begin : main
        void'($urandom(17785));
        for (int i = 0; i < DELAY_N; i++) begin
            rdy_delay[i]  = $urandom % 6;
            data_delay[i] = $urandom % 6;
        end
        rst           = 1'b1;
        rreq_i        = 1'b0;
        raddr_i       = '0;
        axi_rdy_i     = 1'b0;
        axi_rvalid_i  = 1'b0;
        axi_data_i    = '0;
        invalid_i     = 1'b0;
        cacop_i       = 1'b0;
        cacop_way_i   = '0;
        cacop_index_i = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_for_sweep();
        for (int i = 0; i < NSTEP; i++) begin
            case (STEPS[i].op)
                OP_READ:  issue_read(STEPS[i].addr, STEPS[i].exp);
                OP_CACOP: clear_entry(STEPS[i].way, STEPS[i].index);
                default:  invalidate_all();
            endcase
        end
        @(posedge clk);
        if (uut.u_assert.error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("A protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- all.f
icache_cfg_pkg.sv
icache_types_pkg.sv
ram_port_if.sv
icache_ram.sv
icache_maint.sv
icache_ctrl.sv
icache_top.sv
tb_icache_assertions.sv
tb_icache.sv
